// ==== fp_conv_top.f ====
hw/fp_conv_pkg.sv
hw/delay_buffer.sv
hw/oehb.sv
hw/tehb.sv
hw/uitofp.sv
hw/fp_conv_top.sv
testbench/fp_conv_tb.sv

// ==== hw/delay_buffer.sv ====
`timescale 1ns/1ns

module delay_buffer import fp_conv_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic ins_valid,
    // Advance enable, shared with the data pipeline
    input  logic outs_ready,
    output logic outs_valid
);

    // ------------------------------
    // Valid shift register
    // ------------------------------

    // One stage fewer than the data pipeline
    // The output half buffer adds the last cycle
    localparam int DEPTH = CONV_LATENCY - 1;

    logic [DEPTH-1:0] stages;

    always_ff @(posedge clk) begin
        if (rst) begin
            // Nothing in flight after reset
            stages <= '0;
        end else if (outs_ready) begin
            // Shift in at bit 0, oldest token at the top
            stages <= {stages[DEPTH-2:0], ins_valid};
        end
        // Enable low, every stage holds its token
    end

    // ------------------------------
    // Output
    // ------------------------------

    // Top stage lines up with q3 of the data pipeline
    assign outs_valid = stages[DEPTH-1];

endmodule

// ==== hw/fp_conv_pkg.sv ====
package fp_conv_pkg;

    // ------------------------------
    // Stream and float widths
    // ------------------------------
    localparam int INT_W    = 32;
    localparam int FP_W     = 32;
    localparam int EXP_W    = 8;
    localparam int FRAC_W   = 23;
    localparam int EXP_BIAS = 127;

    // Leading-zero count must hold 0..INT_W
    localparam int LZC_W = $clog2(INT_W) + 1;

    // Data pipeline depth; the valid delay line is one shorter
    localparam int CONV_LATENCY = 5;

    // ------------------------------
    // Single-precision word
    // ------------------------------
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp32_fields_t;

    // Raw bus view and field view of the same word
    typedef union packed {
        logic [FP_W-1:0] raw;
        fp32_fields_t    fields;
    } fp32_word;

endpackage

// ==== hw/fp_conv_top.sv ====
`timescale 1ns/1ns

module fp_conv_top import fp_conv_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    // Integer producer side
    input  logic [INT_W-1:0] ins,
    input  logic             ins_valid,
    output logic             ins_ready,
    // Float consumer side
    output logic [FP_W-1:0]  outs,
    output logic             outs_valid,
    input  logic             outs_ready
);

    // ------------------------------
    // Buffer to converter stream
    // ------------------------------
    logic [INT_W-1:0] buf_data;
    logic             buf_valid;
    logic             buf_ready;

    // ------------------------------
    // Input buffer
    // ------------------------------

    // Cuts the converter ready path away from the producer
    tehb i_tehb (
        .clk        (clk),
        .rst        (rst),
        .ins        (ins),
        .ins_valid  (ins_valid),
        .ins_ready  (ins_ready),
        .outs       (buf_data),
        .outs_valid (buf_valid),
        .outs_ready (buf_ready)
    );

    // ------------------------------
    // Converter
    // ------------------------------

    // Five-cycle pipe, stalls as a whole under back-pressure
    uitofp i_uitofp (
        .clk        (clk),
        .rst        (rst),
        .ins        (buf_data),
        .ins_valid  (buf_valid),
        .ins_ready  (buf_ready),
        .outs       (outs),
        .outs_valid (outs_valid),
        .outs_ready (outs_ready)
    );

endmodule

// ==== hw/oehb.sv ====
`timescale 1ns/1ns

module oehb (
    input  logic clk,
    input  logic rst,
    // Upstream side
    input  logic ins,
    input  logic ins_valid,
    output logic ins_ready,
    // Downstream side
    output logic outs,
    output logic outs_valid,
    input  logic outs_ready
);

    // ------------------------------
    // Storage
    // ------------------------------
    logic valid_q;
    logic data_q;

    // Free slot, or the held item leaves this cycle
    assign ins_ready = ~valid_q | outs_ready;

    // Valid flag is control state
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (ins_ready) begin
            // Load new token, or go empty if none offered
            valid_q <= ins_valid;
        end
    end

    // Payload bit follows the valid flag
    always_ff @(posedge clk) begin
        if (ins_ready) begin
            data_q <= ins;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------

    // Fully registered toward the consumer
    assign outs       = data_q;
    assign outs_valid = valid_q;

endmodule

// ==== hw/tehb.sv ====
`timescale 1ns/1ns

module tehb import fp_conv_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    // Upstream side
    input  logic [INT_W-1:0] ins,
    input  logic             ins_valid,
    output logic             ins_ready,
    // Downstream side
    output logic [INT_W-1:0] outs,
    output logic             outs_valid,
    input  logic             outs_ready
);

    // ------------------------------
    // Skid slot
    // ------------------------------
    logic             full;
    logic [INT_W-1:0] slot;

    // Upstream may send only while the slot is free
    // State only, so no combinational path from outs_ready
    assign ins_ready = ~full;

    // Item offered downstream but refused
    logic stall_in;
    assign stall_in = ins_valid & ~full & ~outs_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (stall_in) begin
            // Park the refused item
            full <= 1'b1;
        end else if (full && outs_ready) begin
            // Parked item taken, back to pass-through
            full <= 1'b0;
        end
    end

    // Capture only when empty; a full slot keeps its word
    always_ff @(posedge clk) begin
        if (!full) begin
            slot <= ins;
        end
    end

    // ------------------------------
    // Output select
    // ------------------------------

    // Slot drains first, otherwise input goes straight through
    always_comb begin
        if (full) begin
            outs = slot;
        end else begin
            outs = ins;
        end
    end

    assign outs_valid = full | ins_valid;

endmodule

// ==== hw/uitofp.sv ====
`timescale 1ns/1ns

module uitofp import fp_conv_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    // Integer stream in
    input  logic [INT_W-1:0] ins,
    input  logic             ins_valid,
    output logic             ins_ready,
    // Float stream out
    output logic [FP_W-1:0]  outs,
    output logic             outs_valid,
    input  logic             outs_ready
);

    // ------------------------------
    // Leading-zero count
    // ------------------------------
    logic [LZC_W-1:0] lzc;

    // Highest set bit wins, loop runs low to high
    always_comb begin
        lzc = LZC_W'(INT_W);
        for (int i = 0; i < INT_W; i++) begin
            if (ins[i]) begin
                lzc = LZC_W'(INT_W - 1 - i);
            end
        end
    end

    // ------------------------------
    // Normalize and assemble
    // ------------------------------
    logic [INT_W-1:0] shifted;
    fp32_word         conv;

    // Leading one lands in the MSB
    assign shifted = ins << lzc;

    always_comb begin
        conv.raw = '0;
        if (ins != '0) begin
            // Unsigned source, sign stays clear
            conv.fields.sign = 1'b0;
            conv.fields.exp  = EXP_W'(INT_W - 1 - int'(lzc) + EXP_BIAS);
            // Hidden one dropped, bits below the kept 23 truncated
            conv.fields.frac = shifted[INT_W-2 -: FRAC_W];
        end
        // Zero input gives all-zero word
    end

    // ------------------------------
    // Data pipeline
    // ------------------------------
    fp32_word q0;
    fp32_word q1;
    fp32_word q2;
    fp32_word q3;
    fp32_word q4;

    // Whole pipe moves only when the output buffer can take a token
    logic pipe_en;

    always_ff @(posedge clk) begin
        if (pipe_en) begin
            q0 <= conv;
            q1 <= q0;
            q2 <= q1;
            q3 <= q2;
            q4 <= q3;
        end
    end

    assign outs = q4.raw;

    // ------------------------------
    // Valid tracking
    // ------------------------------
    logic buff_valid;

    // Valid reaches the delay output together with q3
    delay_buffer i_delay_buffer (
        .clk        (clk),
        .rst        (rst),
        .ins_valid  (ins_valid),
        .outs_ready (pipe_en),
        .outs_valid (buff_valid)
    );

    // ------------------------------
    // Output half buffer
    // ------------------------------

    // Registers outs_valid in step with the q3 to q4 move
    // Token bit is carried but the word itself comes from q4
    oehb i_oehb (
        .clk        (clk),
        .rst        (rst),
        .ins        (q4.raw[0]),
        .ins_valid  (buff_valid),
        .ins_ready  (pipe_en),
        .outs       (),
        .outs_valid (outs_valid),
        .outs_ready (outs_ready)
    );

    // Same enable gates acceptance from upstream
    assign ins_ready = pipe_en;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module fp_conv_tb \
    -f fp_conv_top.f -o fp_conv_tb \
    || { echo "Verilator build failed"; exit 1; }

# Simulator exit status is not used, the log is searched instead
./obj_dir/fp_conv_tb > sim.log 2>&1 || true
cat sim.log

grep -q "Something failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "Everything OK" sim.log || { echo "RESULT: FAIL, run did not finish"; exit 1; }
echo "RESULT: PASS"
exit 0

// ==== testbench/fp_conv_tb.sv ====
`timescale 1ns/1ns

module fp_conv_tb import fp_conv_pkg::*; ();

    // ------------------------------
    // DUT signals
    // ------------------------------
    logic             clk = 1'b0;
    logic             rst;
    logic [INT_W-1:0] ins;
    logic             ins_valid;
    logic             ins_ready;
    logic [FP_W-1:0]  outs;
    logic             outs_valid;
    logic             outs_ready;

    fp_conv_top i_fp_conv_top (
        .clk        (clk),
        .rst        (rst),
        .ins        (ins),
        .ins_valid  (ins_valid),
        .ins_ready  (ins_ready),
        .outs       (outs),
        .outs_valid (outs_valid),
        .outs_ready (outs_ready)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // ------------------------------
    // Bench state
    // ------------------------------
    integer          seed = 32'h4684_1fbc;
    int              timeout_cycles = 2000;
    int unsigned     cycle = 0;
    int unsigned     accepted = 0;
    int unsigned     delivered = 0;
    bit              timed = 1'b0;
    bit              prev_blocked = 1'b0;
    logic [FP_W-1:0] prev_outs;

    // Expected words in arrival order with accept cycle and latency flag
    fp32_word        exp_q[$];
    int unsigned     acc_q[$];
    bit              timed_q[$];

    task automatic end_in_failure();
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        $display("CHECK FAILED at %0t ns: %s expected 0x%08h, got 0x%08h",
                 $time, name, want, got);
        end_in_failure();
    endtask

    task automatic report_error(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        end_in_failure();
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------

    // Truncating unsigned to single precision
    function automatic fp32_word expected_float(input logic [INT_W-1:0] value);
        fp32_word         word;
        int               msb;
        logic [INT_W-1:0] mant;
        word.raw = '0;
        msb = -1;
        // Position of the leading one if any
        for (int b = INT_W - 1; b >= 0; b--) begin
            if (msb < 0 && value[b]) begin
                msb = b;
            end
        end
        if (msb >= 0) begin
            // Hidden one removed and the rest lined up under the binary point
            mant = value & ~(32'd1 << msb);
            word.fields.exp = EXP_W'(msb + EXP_BIAS);
            if (msb >= FRAC_W) begin
                word.fields.frac = FRAC_W'(mant >> (msb - FRAC_W));
            end else begin
                word.fields.frac = FRAC_W'(mant << (FRAC_W - msb));
            end
        end
        return word;
    endfunction

    function automatic logic [INT_W-1:0] random_word();
        logic [INT_W-1:0] value;
        value = $random(seed);
        // Spread the leading-zero count over the whole range
        return value >> ($unsigned($random(seed)) % INT_W);
    endfunction

    function automatic int percent_roll();
        return int'($unsigned($random(seed)) % 100);
    endfunction

    // ------------------------------
    // Scoreboard
    // ------------------------------
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Everything here sees pre-edge values
    always @(posedge clk) begin
        fp32_word    got;
        fp32_word    want;
        int unsigned acc_cycle;
        bit          was_timed;
        if (!rst) begin
            if (ins_valid && ins_ready) begin
                exp_q.push_back(expected_float(ins));
                acc_q.push_back(cycle);
                timed_q.push_back(timed);
                accepted <= accepted + 1;
            end
            // Blocked output must hold still
            if (prev_blocked) begin
                assert (outs_valid) else report_mismatch("outs_valid", 32'd1, 32'd0);
                assert (outs == prev_outs) else report_mismatch("outs", prev_outs, outs);
            end
            if (outs_valid && outs_ready) begin
                if (exp_q.size() == 0) begin
                    report_error("output word arrived with no input left to match");
                end else begin
                    want      = exp_q.pop_front();
                    acc_cycle = acc_q.pop_front();
                    was_timed = timed_q.pop_front();
                    got.raw   = outs;
                    assert (got.fields.sign == 1'b0)
                        else report_mismatch("outs.sign", 32'd0, 32'(got.fields.sign));
                    assert (got.fields.exp == want.fields.exp)
                        else report_mismatch("outs.exp", 32'(want.fields.exp),
                                             32'(got.fields.exp));
                    assert (got.fields.frac == want.fields.frac)
                        else report_mismatch("outs.frac", 32'(want.fields.frac),
                                             32'(got.fields.frac));
                    // Free-flowing output gives a fixed delay
                    if (was_timed) begin
                        assert (cycle == acc_cycle + CONV_LATENCY)
                            else report_mismatch("outs_valid cycle",
                                                 acc_cycle + CONV_LATENCY, cycle);
                    end
                    delivered <= delivered + 1;
                end
            end
        end
        prev_blocked <= !rst && outs_valid && !outs_ready;
        prev_outs    <= outs;
    end

    // ------------------------------
    // Stimulus tasks
    // ------------------------------

    // Present one word and hold it until taken
    task automatic send_word(input logic [INT_W-1:0] value);
        int waited;
        waited    = 0;
        ins       <= value;
        ins_valid <= 1'b1;
        @(posedge clk);
        while (!ins_ready && waited < timeout_cycles) begin
            @(posedge clk);
            waited++;
        end
        if (!ins_ready) begin
            report_error("input word not accepted before timeout");
        end
    endtask

    // Release the output and wait for every accepted word
    task automatic drain_outputs();
        int waited;
        waited     = 0;
        ins_valid  <= 1'b0;
        outs_ready <= 1'b1;
        @(posedge clk);
        while (accepted != delivered && waited < timeout_cycles) begin
            @(posedge clk);
            waited++;
        end
        if (accepted != delivered) begin
            report_error("words still in flight after drain timeout");
        end
        // No duplicate may trail the last word
        for (int i = 0; i < 2 * CONV_LATENCY; i++) begin
            @(posedge clk);
            assert (!outs_valid) else report_mismatch("outs_valid", 32'd0, 32'd1);
        end
    endtask

    // Random traffic on both sides
    // Counts cycles with the input blocked
    task automatic stream_cycles(input int cycles, input int valid_pct, input int ready_pct,
                                 output int stalls);
        int waited;
        stalls = 0;
        waited = 0;
        for (int c = 0; c < cycles; c++) begin
            // New word only once the last one was taken
            if (!ins_valid || ins_ready) begin
                if (percent_roll() < valid_pct) begin
                    ins       <= random_word();
                    ins_valid <= 1'b1;
                end else begin
                    ins_valid <= 1'b0;
                end
            end
            outs_ready <= (percent_roll() < ready_pct);
            @(posedge clk);
            if (outs_valid && !outs_ready && !ins_ready) begin
                stalls++;
            end
        end
        // Close an open handshake before going idle
        while (ins_valid && !ins_ready && waited < timeout_cycles) begin
            outs_ready <= 1'b1;
            @(posedge clk);
            waited++;
        end
        if (ins_valid && !ins_ready) begin
            report_error("pending input never accepted at end of traffic");
        end
        ins_valid <= 1'b0;
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int stalls;
        rst        = 1'b1;
        ins        = '0;
        ins_valid  = 1'b0;
        outs_ready = 1'b0;

        // Ten reset cycles
        // State is settled from the second edge on
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            if (i > 0) begin
                assert (!outs_valid) else report_mismatch("outs_valid", 32'd0, 32'd1);
                assert (ins_ready) else report_mismatch("ins_ready", 32'd1, 32'd0);
            end
        end
        rst        <= 1'b0;
        outs_ready <= 1'b1;
        @(posedge clk);
        assert (!outs_valid) else report_mismatch("outs_valid", 32'd0, 32'd1);
        assert (ins_ready) else report_mismatch("ins_ready", 32'd1, 32'd0);

        // Directed values back to back with the output always ready
        timed <= 1'b1;
        send_word(32'h0000_0000);
        send_word(32'h0000_0001);
        send_word(32'h0000_0002);
        send_word(32'h0000_0003);
        send_word(32'h8000_0000);
        send_word(32'hFFFF_FFFF);
        send_word(32'h00FF_FFFF);
        // Low bit falls off the fraction
        send_word(32'h0100_0001);
        for (int n = 0; n < 200; n++) begin
            send_word(random_word());
        end
        drain_outputs();
        timed <= 1'b0;

        // Output held off so the pipe and input buffer fill up
        stream_cycles(40, 100, 0, stalls);
        assert (stalls > 0) else report_error("ins_ready never dropped with output blocked");
        drain_outputs();

        // Random gaps on input and random stalls on output
        stream_cycles(800, 70, 40, stalls);
        assert (stalls > 0) else report_error("ins_ready never dropped under random stalls");
        drain_outputs();

        $display("Everything OK");
        $finish;
    end

endmodule
